/* Makefile */
# Verilator build and run of the hidden-layer testbench
TOP := tb_mlp_hidden

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f $(wildcard src/*.sv tb/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f

# the log decides pass or fail
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^=== PASS ===$$" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir sim.log

/* all.f */
src/mlp_pkg.sv
src/hid_ram_if.sv
src/hidden_ram.sv
src/lane_datapath.sv
src/layer_sequencer.sv
src/mlp_hidden_top.sv
tb/tb_mlp_hidden_properties.sv
tb/tb_mlp_hidden.sv

/* src/hid_ram_if.sv */
// ####################
// hidden RAM port; rdata lags addr by one clock
// ####################
`default_nettype none

interface hid_ram_if;

	logic [mlp_pkg::ROW_W-1:0]  addr;  // row select, from the sequencer
	logic                       wren;  // write strobe
	logic [mlp_pkg::LINE_W-1:0] wdata; // result register of the datapath
	logic [mlp_pkg::LINE_W-1:0] rdata; // registered read

	// sequencer owns address and strobe
	modport seq (output addr, output wren);

	// datapath writes results, reads old row
	modport dp (output wdata, input rdata);

	// storage side
	modport ram (input addr, input wren, input wdata, output rdata);

endinterface

`default_nettype wire

/* src/hidden_ram.sv */
// ####################
// contents power up unknown and the first pixel overwrites every row
// ####################
`default_nettype none

module hidden_ram (
	input wire   clk,
	hid_ram_if.ram ram
);

	// 16 rows x 4 lanes
	logic [mlp_pkg::LINE_W-1:0] mem [mlp_pkg::HID_ROWS];

	// write port
	always_ff @(posedge clk) begin
		if (ram.wren) begin
			mem[ram.addr] <= ram.wdata;
		end
	end

	// registered read with one clock of latency
	// rdata holds its value through a write cycle
	always_ff @(posedge clk) begin
		if (!ram.wren) begin
			ram.rdata <= mem[ram.addr];
		end
	end

endmodule

`default_nettype wire

/* src/lane_datapath.sv */
// ####################
// integer lanes where products keep the low 32 bits and sums wrap
// ####################
`default_nettype none

module lane_datapath (
	input wire                            clk,
	input wire                            reset,
	input wire [mlp_pkg::WORD_W-1:0]      din,     // current pixel value
	input wire [mlp_pkg::LINE_W-1:0]      data,    // weight or bias line from FIFO
	input wire [mlp_pkg::LANE_OP_W-1:0]   op,
	input wire                            clear,   // treat stored row as zero
	input wire                            capture, // load result register
	hid_ram_if.dp                         ram
);

	logic [mlp_pkg::LINE_W-1:0] line_next; // combinational lane results
	logic [mlp_pkg::LINE_W-1:0] line_q;    // result register

	genvar i;
	generate
		for (i = 0; i < mlp_pkg::LANES; i++) begin : g_lane
			logic [mlp_pkg::WORD_W-1:0] old;  // stored neuron value
			logic [mlp_pkg::WORD_W-1:0] coef; // weight or bias for this lane
			logic [mlp_pkg::WORD_W-1:0] prod; // low half of din * weight
			logic [mlp_pkg::WORD_W-1:0] res;

			// first pixel starts the sum from zero
			assign old  = clear ? '0 : ram.rdata[i*mlp_pkg::WORD_W +: mlp_pkg::WORD_W];
			assign coef = data[i*mlp_pkg::WORD_W +: mlp_pkg::WORD_W];
			assign prod = din * coef; // low bits match a signed multiply

			always_comb begin
				case (op)
					mlp_pkg::LANE_OP_MAC:  res = old + prod;
					mlp_pkg::LANE_OP_BIAS: res = old + coef;
					// negative lanes drop to zero
					mlp_pkg::LANE_OP_RELU: res = old[mlp_pkg::WORD_W-1] ? '0 : old;
					default:               res = old; // unused code leaves row unchanged
				endcase
			end

			// lane 0 in the low bits as in the FIFO line
			assign line_next[i*mlp_pkg::WORD_W +: mlp_pkg::WORD_W] = res;
		end
	endgenerate

	// one clock from capture to wdata
	always_ff @(posedge clk) begin
		if (reset) begin
			line_q <= '0;
		end else if (capture) begin
			line_q <= line_next;
		end
	end

	assign ram.wdata = line_q; // also the activation stream of the top level

endmodule

`default_nettype wire

/* src/layer_sequencer.sv */
// ####################
// one-shot layer where done holds until reset and start is ignored after that
// rows are fetch, load and write; fetch stalls while the FIFO is empty
// ####################
`default_nettype none

module layer_sequencer (
	input wire                           clk,
	input wire                           reset,
	input wire                           start,
	input wire                           empty,     // FIFO has no line
	output logic                         fifo_rd,   // pop with line valid next clock
	output logic                         next_in,   // ask for the next pixel
	output logic                         act_valid, // relu line on act_line
	output logic                         done,
	output logic [mlp_pkg::LANE_OP_W-1:0] op,
	output logic                         clear,
	output logic                         capture,
	hid_ram_if.seq                       ram
);

	enum logic [2:0] {
		S_IDLE,
		S_FETCH, // pop FIFO while RAM reads the row
		S_LOAD,  // capture data and rdata
		S_WRITE, // result back into the row
		S_DONE
	} state;

	logic [mlp_pkg::LANE_OP_W-1:0] pass; // current pass and lane op
	logic [mlp_pkg::ROW_W-1:0]     row;
	logic [mlp_pkg::PIX_W-1:0]     pix;

	logic last_row;
	logic last_pix;
	logic fifo_pass; // mac and bias passes consume FIFO lines

	assign last_row  = row == (mlp_pkg::ROW_W)'(mlp_pkg::HID_ROWS - 1);
	assign last_pix  = pix == (mlp_pkg::PIX_W)'(mlp_pkg::N_PIXELS - 1);
	assign fifo_pass = pass != mlp_pkg::LANE_OP_RELU;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			pass  <= mlp_pkg::LANE_OP_MAC;
			row   <= '0;
			pix   <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start) begin
						state <= S_FETCH;
						pass  <= mlp_pkg::LANE_OP_MAC;
						row   <= '0;
						pix   <= '0;
					end
				end

				S_FETCH: begin
					// relu pass reads the RAM only and never waits
					if (!fifo_pass || !empty) begin
						state <= S_LOAD;
					end
				end

				S_LOAD: state <= S_WRITE;

				S_WRITE: begin
					state <= S_FETCH;
					if (last_row) begin
						row <= '0;
						case (pass)
							mlp_pkg::LANE_OP_MAC: begin
								if (last_pix) begin
									pix  <= '0;
									pass <= mlp_pkg::LANE_OP_BIAS; // image finished
								end else begin
									pix <= pix + 1'b1;
								end
							end
							mlp_pkg::LANE_OP_BIAS: pass <= mlp_pkg::LANE_OP_RELU;
							default: state <= S_DONE; // relu row 15 written
						endcase
					end else begin
						row <= row + 1'b1;
					end
				end

				S_DONE: state <= S_DONE; // hold until reset

				default: state <= S_IDLE;
			endcase
		end
	end

	// empty is only looked at here
	assign fifo_rd = (state == S_FETCH) && fifo_pass && !empty;

	// pixel request in the write of row 15 of every pixel
	assign next_in = (state == S_WRITE) && (pass == mlp_pkg::LANE_OP_MAC) && last_row;

	assign act_valid = (state == S_WRITE) && (pass == mlp_pkg::LANE_OP_RELU);
	assign done      = state == S_DONE;

	// datapath control
	assign op      = pass;
	assign clear   = (pass == mlp_pkg::LANE_OP_MAC) && (pix == '0); // first pixel
	assign capture = state == S_LOAD;

	// row counter is the RAM address in every state
	assign ram.addr = row;
	assign ram.wren = state == S_WRITE;

endmodule

`default_nettype wire

/* src/mlp_hidden_top.sv */
// ####################
// hidden layer only; weights then biases arrive on data with row 0 first
// ####################
`default_nettype none

module mlp_hidden_top (
	input wire                          clk,
	input wire                          reset,
	input wire                          start,
	input wire [mlp_pkg::WORD_W-1:0]    din,       // pixel held for 16 rows
	input wire [mlp_pkg::LINE_W-1:0]    data,      // FIFO read data
	input wire                          empty,
	output logic                        fifo_rd,
	output logic                        next_in,
	output logic                        act_valid,
	output logic                        done,
	output logic [mlp_pkg::LINE_W-1:0]  act_line
);

	logic [mlp_pkg::LANE_OP_W-1:0] op;
	logic                          clear;
	logic                          capture;

	hid_ram_if ram_bus (); // shared by all three blocks

	layer_sequencer u_seq (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.empty     (empty),
		.fifo_rd   (fifo_rd),
		.next_in   (next_in),
		.act_valid (act_valid),
		.done      (done),
		.op        (op),
		.clear     (clear),
		.capture   (capture),
		.ram       (ram_bus.seq)
	);

	lane_datapath u_dp (
		.clk     (clk),
		.reset   (reset),
		.din     (din),
		.data    (data),
		.op      (op),
		.clear   (clear),
		.capture (capture),
		.ram     (ram_bus.dp)
	);

	hidden_ram u_ram (
		.clk (clk),
		.ram (ram_bus.ram)
	);

	// written line is the activation while act_valid is high
	assign act_line = ram_bus.wdata;

endmodule

`default_nettype wire

/* src/mlp_pkg.sv */
// ####################
// sizes for a 6-pixel, 64-neuron hidden layer; lanes wrap at 32 bits
// ####################
`default_nettype none

package mlp_pkg;

	// line geometry
	localparam int LANES  = 4;              // lanes per RAM or FIFO line
	localparam int WORD_W = 32;             // one signed two's-complement lane
	localparam int LINE_W = LANES * WORD_W; // 128

	// hidden RAM holds 4 neurons per row
	localparam int HID_ROWS = 16;           // 64 neurons
	localparam int ROW_W    = 4;

	// input image
	localparam int N_PIXELS = 6;            // full image would be 784
	localparam int PIX_W    = 3;

	// lane operation codes
	localparam int LANE_OP_W = 2;
	localparam logic [LANE_OP_W-1:0] LANE_OP_MAC  = 2'd0; // old + din * weight
	localparam logic [LANE_OP_W-1:0] LANE_OP_BIAS = 2'd1; // old + bias
	localparam logic [LANE_OP_W-1:0] LANE_OP_RELU = 2'd2; // clamp negatives to zero

endpackage

`default_nettype wire

/* tb/tb_mlp_hidden.sv */
// ####################
// layer is one-shot, so every test starts with a reset
// weight and bias lanes are small signed values from a fixed-seed xorshift
// ####################
`default_nettype none

module tb_mlp_hidden;

	localparam int LW      = mlp_pkg::LINE_W;
	localparam int NPIX    = mlp_pkg::N_PIXELS;
	localparam int ROWS    = mlp_pkg::HID_ROWS;
	localparam int N_LINES = NPIX * ROWS + ROWS; // weight lines followed by bias lines
	localparam int N_TESTS = 3;
	localparam int TIMEOUT = 5000;               // cycles per test

	logic          clk;
	logic          reset;
	logic          start;
	logic [31:0]   din;
	logic [LW-1:0] data;
	logic          empty;
	wire           fifo_rd;
	wire           next_in;
	wire           act_valid;
	wire           done;
	wire  [LW-1:0] act_line;

	// stimulus table with name, pixels, gap percent, expected pops and pixel requests
	string       test_name [N_TESTS] = '{"no_gaps", "light_gaps", "heavy_gaps"};
	logic [31:0] test_pix [N_TESTS][NPIX] = '{
		'{32'd1, 32'd2, 32'd3, 32'd4, 32'd5, 32'd6},
		'{32'd0, 32'd3, 32'd255, 32'd17, 32'd2, 32'd9},
		'{32'h0100_0000, 32'hffff_fff0, 32'd7, 32'h7fff_ffff, 32'd1, 32'd40} // wraps
	};
	int          test_gap  [N_TESTS] = '{0, 25, 70}; // percent of cycles with empty high
	int          test_reads[N_TESTS] = '{N_LINES, N_LINES, N_LINES};
	int          test_reqs [N_TESTS] = '{NPIX, NPIX, NPIX};

	logic [LW-1:0] lines    [N_LINES]; // FIFO contents in pop order
	logic [LW-1:0] expected [ROWS];    // ReLU lines from the model
	logic [31:0]   rng = 32'h94f7_2646;
	string         cur_test;

	mlp_hidden_top uut (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.din       (din),
		.data      (data),
		.empty     (empty),
		.fifo_rd   (fifo_rd),
		.next_in   (next_in),
		.act_valid (act_valid),
		.done      (done),
		.act_line  (act_line)
	);

	bind layer_sequencer tb_mlp_hidden_properties u_props (
		.clk       (clk),
		.reset     (reset),
		.empty     (empty),
		.fifo_rd   (fifo_rd),
		.act_valid (act_valid),
		.done      (done)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped at first failure");
	endtask

	task automatic check_value(input string what, input logic [LW-1:0] exp,
			input logic [LW-1:0] act);
		if (act !== exp) begin
			stop_with_failure($sformatf("ERROR %s %s: expected 0x%0h, actual 0x%0h",
				cur_test, what, exp, act));
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// lanes in -128..127 so sums land on both sides of zero
	task automatic make_lines();
		for (int n = 0; n < N_LINES; n++) begin
			for (int l = 0; l < mlp_pkg::LANES; l++) begin
				rng = xorshift(rng);
				lines[n][l*32 +: 32] = (rng & 32'h0000_00ff) - 32'd128;
			end
		end
	endtask

	// din * weight summed over pixels plus bias with negatives clamped, mod 2^32
	task automatic build_expected(input int t);
		logic [31:0] acc;
		int          zeros;
		int          live;
		zeros = 0;
		live  = 0;
		for (int r = 0; r < ROWS; r++) begin
			for (int l = 0; l < mlp_pkg::LANES; l++) begin
				acc = '0;
				for (int p = 0; p < NPIX; p++) begin
					acc = acc + test_pix[t][p] * lines[p*ROWS + r][l*32 +: 32];
				end
				acc = acc + lines[NPIX*ROWS + r][l*32 +: 32]; // bias line of row r
				expected[r][l*32 +: 32] = acc[31] ? 32'd0 : acc;
				if (acc[31]) zeros++;
				else live++;
			end
		end
		if (zeros == 0 || live == 0) begin
			stop_with_failure({"test ", cur_test, " gives lanes of one sign only"});
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1;
		reset = 1'b1;
		start = 1'b0;
		empty = 1'b1;
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;
		@(negedge clk); // idle outputs
		check_value("fifo_rd after reset", '0, LW'(fifo_rd));
		check_value("next_in after reset", '0, LW'(next_in));
		check_value("act_valid after reset", '0, LW'(act_valid));
		check_value("done after reset", '0, LW'(done));
	endtask

	task automatic run_test(input int t);
		int   reads;
		int   reqs;
		int   acts;
		logic popped;
		logic req;
		logic done_seen;
		reads     = 0;
		reqs      = 0;
		acts      = 0;
		done_seen = 1'b0;
		@(posedge clk);
		#1;
		start = 1'b1;
		din   = test_pix[t][0];
		for (int cyc = 0; cyc < TIMEOUT && !done_seen; cyc++) begin
			@(negedge clk); // outputs settled mid-cycle
			popped = fifo_rd;
			req    = next_in;
			if (fifo_rd && empty) stop_with_failure({cur_test, ": fifo_rd fired while empty"});
			if (fifo_rd && act_valid) stop_with_failure({cur_test, ": pop during ReLU output"});
			if (fifo_rd) reads++;
			if (next_in) reqs++;
			if (act_valid) begin
				if (acts == 0) check_value("next_in pulses", LW'(test_reqs[t]), LW'(reqs));
				check_value($sformatf("act_line row %0d", acts), expected[acts], act_line);
				acts++;
			end
			if (done) begin
				check_value("act_valid count at done", LW'(ROWS), LW'(acts));
				check_value("fifo_rd pulses", LW'(test_reads[t]), LW'(reads));
				done_seen = 1'b1;
			end
			@(posedge clk);
			#1;
			start = 1'b0;
			if (popped) data = lines[reads-1];     // popped line is valid in load
			if (req && reqs < NPIX) din = test_pix[t][reqs];
			rng   = xorshift(rng);
			empty = (reads >= N_LINES) || ((rng % 100) < test_gap[t]);
		end
		if (!done_seen) begin
			stop_with_failure($sformatf("timeout in %s: done did not rise within %0d cycles",
				cur_test, TIMEOUT));
		end
		for (int k = 0; k < 5; k++) begin
			@(negedge clk); // done holds while nothing else moves
			check_value("done hold", LW'(1), LW'(done));
			check_value("fifo_rd after done", '0, LW'(fifo_rd));
			check_value("act_valid after done", '0, LW'(act_valid));
		end
	endtask

	initial begin
		reset = 1'b1;
		start = 1'b0;
		din   = '0;
		data  = '0;
		empty = 1'b1;
		for (int t = 0; t < N_TESTS; t++) begin
			cur_test = test_name[t];
			make_lines();
			build_expected(t);
			apply_reset();
			run_test(t);
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/tb_mlp_hidden_properties.sv */
// ####################
// bound into layer_sequencer and idle while reset is high
// ####################
`default_nettype none

module tb_mlp_hidden_properties (
	input wire clk,
	input wire reset,
	input wire empty,
	input wire fifo_rd,
	input wire act_valid,
	input wire done
);

	// a pop needs a line in the FIFO
	property p_no_pop_when_empty;
		@(posedge clk) disable iff (reset) !(fifo_rd && empty);
	endproperty

	// relu pass reads the RAM only
	property p_no_pop_with_act;
		@(posedge clk) disable iff (reset) !(fifo_rd && act_valid);
	endproperty

	// done only clears through reset
	property p_done_sticky;
		@(posedge clk) disable iff (reset) !$fell(done);
	endproperty

	a_no_pop_when_empty: assert property (p_no_pop_when_empty)
		else $error("fifo_rd high while empty is high");
	a_no_pop_with_act: assert property (p_no_pop_with_act)
		else $error("fifo_rd and act_valid high together");
	a_done_sticky: assert property (p_done_sticky)
		else $error("done fell without reset");

endmodule

`default_nettype wire
